// ==== common/fft_agu_pkg.sv ====
package fft_agu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Geometry of the 32-point transform
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_LEVELS     = 5;
    localparam int BFLY_PER_LEVEL = 16;

    // Butterfly datapath latency used when the top level is not overridden
    localparam int WR_LATENCY_DEF = 3;

    // ~~~~~~~~~~~~~~~~~~~~
    // Address and index types
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [4:0] mem_addr_t;
    typedef logic [3:0] bfly_idx_t;
    typedef logic [2:0] level_t;
    typedef logic [3:0] twiddle_addr_t;

    // Operand addresses of one butterfly
    typedef struct packed {
        mem_addr_t a;
        mem_addr_t b;
    } addr_pair_t;

    // One butterfly, named by its level and its index in that level
    typedef struct packed {
        level_t    level;
        bfly_idx_t idx;
    } bfly_t;

endpackage

// ==== design/agu/agu_ctrl.sv ====
`timescale 1ns/100ps

module agu_ctrl #(
    parameter int WR_LATENCY = fft_agu_pkg::WR_LATENCY_DEF
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               start_fft,
    output fft_agu_pkg::bfly_t bfly,
    output logic               bfly_valid,
    output logic               fft_done
);

    import fft_agu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,
        DONE
    } state_t;

    localparam logic [3:0] DRAIN_LAST = 4'(WR_LATENCY - 1);
    localparam bfly_idx_t  IDX_LAST   = bfly_idx_t'(BFLY_PER_LEVEL - 1);
    localparam level_t     LEVEL_LAST = level_t'(NUM_LEVELS - 1);

    state_t     state;
    logic       start_d;
    logic       start_rise;
    bfly_idx_t  idx_cnt;
    level_t     level_cnt;
    logic [3:0] drain_cnt;

    // ~~~~~~~~~~~~~~~~~~~~
    // Start edge register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            start_d    <= 1'b0;
            start_rise <= 1'b0;
        end else begin
            start_d    <= start_fft;
            start_rise <= start_fft & ~start_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Run state machine and counters
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            idx_cnt   <= '0;
            level_cnt <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // A start edge seen in any other state is dropped
                    if (start_rise) begin
                        state     <= READ;
                        idx_cnt   <= '0;
                        level_cnt <= '0;
                    end
                end
                READ: begin
                    idx_cnt <= idx_cnt + 1'b1;
                    if (idx_cnt == IDX_LAST) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    // Wait for the write-back of this level to leave the pipe
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_LAST) begin
                        if (level_cnt == LEVEL_LAST) begin
                            state <= DONE;
                        end else begin
                            state     <= READ;
                            level_cnt <= level_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Done goes out one cycle after DONE, lining it up behind the last write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fft_done <= 1'b0;
        end else begin
            fft_done <= (state == DONE);
        end
    end

    assign bfly_valid = (state == READ);
    assign bfly.level = level_cnt;
    assign bfly.idx   = idx_cnt;

endmodule

// ==== design/agu/agu_addr_map.sv ====
`timescale 1ns/100ps

module agu_addr_map (
    input  logic                       clock,
    input  logic                       rst_n,
    input  fft_agu_pkg::bfly_t         bfly,
    input  logic                       bfly_valid,
    output fft_agu_pkg::addr_pair_t    rd_pair,
    output fft_agu_pkg::twiddle_addr_t twiddle_addr,
    output logic                       rd_en
);

    import fft_agu_pkg::*;

    // Rotate a 5-bit address left by the level
    function automatic mem_addr_t rotl(input mem_addr_t value, input level_t amount);
        logic [9:0] doubled;
        doubled = {value, value} << amount;
        return doubled[9:5];
    endfunction

    mem_addr_t     addr_a;
    mem_addr_t     addr_b;
    twiddle_addr_t twiddle;

    // ~~~~~~~~~~~~~~~~~~~~
    // Address rule
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        addr_a  = rotl({bfly.idx, 1'b0}, bfly.level);
        addr_b  = rotl({bfly.idx, 1'b1}, bfly.level);
        // Upper bits fall off, only 16 twiddles exist
        twiddle = twiddle_addr_t'(bfly.idx << bfly.level);
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= bfly_valid;
        end
    end

    always_ff @(posedge clock) begin
        rd_pair.a    <= addr_a;
        rd_pair.b    <= addr_b;
        twiddle_addr <= twiddle;
    end

endmodule

// ==== design/agu/agu_write_pipe.sv ====
`timescale 1ns/100ps

module agu_write_pipe #(
    parameter int WR_LATENCY = fft_agu_pkg::WR_LATENCY_DEF
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  fft_agu_pkg::addr_pair_t rd_pair,
    input  logic                    rd_en,
    output fft_agu_pkg::addr_pair_t wr_pair,
    output logic                    mem_write
);

    import fft_agu_pkg::*;

    // Stage 0 takes the read side, the last stage feeds the write side
    addr_pair_t            pair_sr [WR_LATENCY];
    logic [WR_LATENCY-1:0] valid_sr;

    // ~~~~~~~~~~~~~~~~~~~~
    // Valid chain
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= rd_en;
            for (int k = 1; k < WR_LATENCY; k++) begin
                valid_sr[k] <= valid_sr[k-1];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Address chain
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        pair_sr[0] <= rd_pair;
        for (int k = 1; k < WR_LATENCY; k++) begin
            pair_sr[k] <= pair_sr[k-1];
        end
    end

    assign wr_pair   = pair_sr[WR_LATENCY-1];
    assign mem_write = valid_sr[WR_LATENCY-1];

endmodule

// ==== design/fft_agu.sv ====
`timescale 1ns/100ps

module fft_agu #(
    parameter int WR_LATENCY = fft_agu_pkg::WR_LATENCY_DEF
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       start_fft,
    output fft_agu_pkg::addr_pair_t    rd_pair,
    output fft_agu_pkg::twiddle_addr_t twiddle_addr,
    output logic                       rd_en,
    output fft_agu_pkg::addr_pair_t    wr_pair,
    output logic                       mem_write,
    output logic                       fft_done
);

    import fft_agu_pkg::*;

    bfly_t      bfly;
    logic       bfly_valid;
    addr_pair_t rd_pair_int;
    logic       rd_en_int;

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequencing
    // ~~~~~~~~~~~~~~~~~~~~
    agu_ctrl #(
        .WR_LATENCY (WR_LATENCY)
    ) u_agu_ctrl (
        .clock      (clock),
        .rst_n      (rst_n),
        .start_fft  (start_fft),
        .bfly       (bfly),
        .bfly_valid (bfly_valid),
        .fft_done   (fft_done)
    );

    // Read addresses, one cycle behind the counters
    agu_addr_map u_agu_addr_map (
        .clock        (clock),
        .rst_n        (rst_n),
        .bfly         (bfly),
        .bfly_valid   (bfly_valid),
        .rd_pair      (rd_pair_int),
        .twiddle_addr (twiddle_addr),
        .rd_en        (rd_en_int)
    );

    // Write-back addresses follow the butterfly latency
    agu_write_pipe #(
        .WR_LATENCY (WR_LATENCY)
    ) u_agu_write_pipe (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_pair   (rd_pair_int),
        .rd_en     (rd_en_int),
        .wr_pair   (wr_pair),
        .mem_write (mem_write)
    );

    assign rd_pair = rd_pair_int;
    assign rd_en   = rd_en_int;

endmodule

// ==== verification/fft_agu_assertions.sv ====
`timescale 1ns/100ps

module fft_agu_assertions #(
    parameter int WR_LATENCY = fft_agu_pkg::WR_LATENCY_DEF
) (
    input logic clock,
    input logic rst_n,
    input logic rd_en,
    input logic mem_write,
    input logic fft_done
);

    int unsigned fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~
    // Strobe relations
    // ~~~~~~~~~~~~~~~~~~~~
    write_after_read: assert property (
        @(posedge clock) disable iff (!rst_n)
        $rose(mem_write) |-> $past(rd_en, WR_LATENCY)
    ) else begin
        $error("mem_write rose without rd_en %0d cycles earlier", WR_LATENCY);
        fail_count++;
    end

    // Done is a single-cycle pulse
    done_one_cycle: assert property (
        @(posedge clock) disable iff (!rst_n)
        fft_done |=> !fft_done
    ) else begin
        $error("fft_done stayed high for more than one cycle");
        fail_count++;
    end

    read_not_with_done: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(rd_en && fft_done)
    ) else begin
        $error("rd_en and fft_done high in the same cycle");
        fail_count++;
    end

endmodule

bind fft_agu fft_agu_assertions #(
    .WR_LATENCY (WR_LATENCY)
) u_fft_agu_assertions (
    .clock     (clock),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .mem_write (mem_write),
    .fft_done  (fft_done)
);

// ==== verification/tb_fft_agu.sv ====
`timescale 1ns/100ps

module tb_fft_agu;

    import fft_agu_pkg::*;

    localparam int WR_LATENCY      = 3;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_ROWS        = 4;
    localparam int GAP_MIN         = 3;
    localparam int GAP_MAX         = GAP_MIN + 15;
    localparam int MID_DELAY       = 20;
    localparam int RUN_CYCLES      = 2 + NUM_LEVELS * (BFLY_PER_LEVEL + WR_LATENCY);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * (RUN_CYCLES + GAP_MAX + 20) + 50;

    typedef struct packed {
        int start_len;
        bit mid_start;
        int exp_reads;
        int exp_writes;
        int exp_done;
    } stim_row_t;

    // Start length, second start mid-run, expected reads, writes, done pulses
    stim_row_t stim_table [NUM_ROWS] = '{
        '{1, 1'b0, 80, 80, 1},
        '{5, 1'b1, 80, 80, 1},
        '{3, 1'b0, 80, 80, 1},
        '{1, 1'b1, 80, 80, 1}
    };

    logic          clock = 1'b0;
    logic          rst_n;
    logic          start_fft;
    addr_pair_t    rd_pair;
    twiddle_addr_t twiddle_addr;
    logic          rd_en;
    addr_pair_t    wr_pair;
    logic          mem_write;
    logic          fft_done;

    bit          quiet = 1'b1;
    int          cycle_count = 0;
    int          run_start_cycle = 0;
    int          run_reads = 0;
    int          run_writes = 0;
    int          last_read_cycle = 0;
    int          last_write_cycle = 0;
    int          reads_total = 0;
    int          writes_total = 0;
    int          done_total = 0;
    logic [15:0] lfsr_state = 16'd4534;
    addr_pair_t  pending_pair [$];
    int          pending_cycle [$];

    fft_agu #(
        .WR_LATENCY (WR_LATENCY)
    ) u_fft_agu (
        .clock        (clock),
        .rst_n        (rst_n),
        .start_fft    (start_fft),
        .rd_pair      (rd_pair),
        .twiddle_addr (twiddle_addr),
        .rd_en        (rd_en),
        .wr_pair      (wr_pair),
        .mem_write    (mem_write),
        .fft_done     (fft_done)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[FAIL] time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic report_error(input string what);
        $display("Error at time %0t: %s", $time, what);
        stop_with_failure();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Gap source and reference model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[0] ^ state[2] ^ state[3] ^ state[5];
        return {feedback, state[15:1]};
    endfunction

    task automatic draw_gap(output int gap);
        logic [3:0] bits;
        bits = '0;
        for (int k = 0; k < 4; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[2:0], lfsr_state[0]};
        end
        gap = GAP_MIN + int'(bits);
    endtask

    function automatic mem_addr_t rotate_left(input mem_addr_t value, input int amount);
        mem_addr_t result;
        result = value;
        for (int k = 0; k < amount; k++) begin
            result = {result[3:0], result[4]};
        end
        return result;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic observe_cycle();
        int         level;
        int         idx;
        addr_pair_t exp_pair;
        addr_pair_t sent_pair;
        int         sent_cycle;
        cycle_count++;
        if (u_fft_agu.u_fft_agu_assertions.fail_count != 0) begin
            report_error("a concurrent assertion on the DUT strobes failed");
        end
        if (quiet && (rd_en || mem_write || fft_done)) begin
            report_error("a strobe went high while no run was active");
        end
        if (rd_en) begin
            level = run_reads / BFLY_PER_LEVEL;
            idx   = run_reads % BFLY_PER_LEVEL;
            if (run_reads >= NUM_LEVELS * BFLY_PER_LEVEL) begin
                report_error("more reads than butterflies in one run");
            end
            // Edge taken at the next clock, rd_en two clocks after that
            if (run_reads == 0) begin
                check_value("first rd_en cycle", cycle_count, run_start_cycle + 4);
            end else if (idx == 0) begin
                check_value("cycles between levels", cycle_count - last_read_cycle,
                            WR_LATENCY + 1);
                check_value("writes before next level", run_writes, level * BFLY_PER_LEVEL);
            end else begin
                check_value("cycles between reads", cycle_count - last_read_cycle, 1);
            end
            exp_pair.a = rotate_left({4'(idx), 1'b0}, level);
            exp_pair.b = rotate_left({4'(idx), 1'b1}, level);
            check_value("rd_pair.a", int'(rd_pair.a), int'(exp_pair.a));
            check_value("rd_pair.b", int'(rd_pair.b), int'(exp_pair.b));
            check_value("twiddle_addr", int'(twiddle_addr), (idx << level) % 16);
            pending_pair.push_back(exp_pair);
            pending_cycle.push_back(cycle_count);
            last_read_cycle = cycle_count;
            run_reads++;
            reads_total++;
        end
        if (mem_write) begin
            if (pending_pair.size() == 0) begin
                report_error("mem_write without an earlier read");
            end
            sent_pair  = pending_pair.pop_front();
            sent_cycle = pending_cycle.pop_front();
            check_value("mem_write latency", cycle_count - sent_cycle, WR_LATENCY);
            check_value("wr_pair.a", int'(wr_pair.a), int'(sent_pair.a));
            check_value("wr_pair.b", int'(wr_pair.b), int'(sent_pair.b));
            last_write_cycle = cycle_count;
            run_writes++;
            writes_total++;
        end
        if (fft_done) begin
            check_value("writes before fft_done", run_writes, NUM_LEVELS * BFLY_PER_LEVEL);
            check_value("fft_done delay", cycle_count - last_write_cycle, 1);
            done_total++;
            run_reads  = 0;
            run_writes = 0;
        end
    endtask

    always @(negedge clock) begin
        observe_cycle();
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic run_row(input stim_row_t row);
        int gap;
        int reads_before;
        int writes_before;
        int done_before;
        draw_gap(gap);
        repeat (gap) @(posedge clock);
        #2;
        reads_before    = reads_total;
        writes_before   = writes_total;
        done_before     = done_total;
        quiet           = 1'b0;
        run_start_cycle = cycle_count;
        start_fft       = 1'b1;
        repeat (row.start_len) @(posedge clock);
        #2;
        start_fft = 1'b0;
        // Second edge lands while the run is busy
        if (row.mid_start) begin
            repeat (MID_DELAY) @(posedge clock);
            #2;
            start_fft = 1'b1;
            repeat (2) @(posedge clock);
            #2;
            start_fft = 1'b0;
        end
        do begin
            @(negedge clock);
        end while (!fft_done);
        @(posedge clock);
        #2;
        quiet = 1'b1;
        repeat (3) @(posedge clock);
        #2;
        check_value("reads in run", reads_total - reads_before, row.exp_reads);
        check_value("writes in run", writes_total - writes_before, row.exp_writes);
        check_value("done pulses in run", done_total - done_before, row.exp_done);
    endtask

    initial begin
        rst_n     = 1'b0;
        start_fft = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        rst_n = 1'b1;
        for (int row = 0; row < NUM_ROWS; row++) begin
            run_row(stim_table[row]);
        end
        $display("TB PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles before the test finished",
                 WATCHDOG_CYCLES);
        stop_with_failure();
    end

endmodule

// ==== files.f ====
common/fft_agu_pkg.sv
design/agu/agu_ctrl.sv
design/agu/agu_addr_map.sv
design/agu/agu_write_pipe.sv
design/fft_agu.sv
verification/fft_agu_assertions.sv
verification/tb_fft_agu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FFT AGU testbench with Verilator

cd "$(dirname "$0")" || { echo "Cannot enter the project root"; exit 1; }
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_fft_agu \
    --Mdir obj_dir -o tb_fft_agu
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_fft_agu +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0
